/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tenyr_soc_tb
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: sim clean

# the awk filter echoes the run and fails unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /Simulation PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

/* bench/tenyr_soc_tb.sv */
`default_nettype none

`include "tenyr_consts.svh"

module tenyr_soc_tb
    import tenyr_bus_pkg::*;
    import tenyr_dev_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TRANSFERS = 400;
    localparam int CYCLE_LIMIT   = 16 + NUM_TRANSFERS * 3 + 200;
    localparam int RAM_WORDS     = 1 << `RAMABITS;

    logic                   clk;
    logic                   rst;
    bus_req_t               req;
    bus_rsp_t               rsp;
    logic [`GPIO_COUNT-1:0] gpio_in;
    logic [`GPIO_COUNT-1:0] gpio_out;
    logic [`GPIO_COUNT-1:0] gpio_oe;
    logic [7:0]             seg;
    logic [3:0]             an;

    // reference model of everything the master can see
    logic [31:0]            model_ram [RAM_WORDS];
    logic [`GPIO_COUNT-1:0] model_out;
    logic [`GPIO_COUNT-1:0] model_dir;
    logic [15:0]            model_value;
    logic [3:0]             model_dp;

    logic [31:0] lcg_state;
    logic        mon_en;
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          cycles          = 0;

    tenyr_soc dut0 (
        .clk_i     (clk),
        .rst_i     (rst),
        .req_i     (req),
        .rsp_o     (rsp),
        .gpio_i    (gpio_in),
        .gpio_o    (gpio_out),
        .gpio_oe_o (gpio_oe),
        .seg_o     (seg),
        .an_o      (an)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // common anode pattern with the point in bit 7
    function automatic logic [7:0] seg_pattern(input seg7_digit_t d, input logic dp);
        logic [7:0] pat;
        case (d)
            4'h0: pat = 8'hC0;
            4'h1: pat = 8'hF9;
            4'h2: pat = 8'hA4;
            4'h3: pat = 8'hB0;
            4'h4: pat = 8'h99;
            4'h5: pat = 8'h92;
            4'h6: pat = 8'h82;
            4'h7: pat = 8'hF8;
            4'h8: pat = 8'h80;
            4'h9: pat = 8'h90;
            4'hA: pat = 8'h88;
            4'hB: pat = 8'h83;
            4'hC: pat = 8'hC6;
            4'hD: pat = 8'hA1;
            4'hE: pat = 8'h86;
            default: pat = 8'h8E;
        endcase
        if (dp) begin
            pat[7] = 1'b0;
        end
        return pat;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one master transfer entered and left 5 ns after a rising edge
    task automatic bus_transfer(input logic [31:0] adr, input logic [31:0] dat,
                                input logic wen, input logic [3:0] sel, input int exp_lat,
                                output logic [31:0] rdata, output logic acked);
        int waits;
        waits = 0;
        acked = 1'b0;
        rdata = '0;
        req.adr = adr;
        req.dat = dat;
        req.wen = wen;
        req.sel = sel;
        req.stb = 1'b1;
        req.cyc = 1'b1;
        while (!acked && waits < 4) begin
            @(negedge clk);            // outputs settled here
            if (rsp.ack) begin
                acked = 1'b1;
                rdata = rsp.dat;
            end else begin
                waits++;
            end
        end
        assert (acked) else begin
            protocol_errors++;
            $display("no acknowledge for address %h after %0d cycles", adr, waits);
        end
        if (acked) begin
            check_value("ack latency", 32'(exp_lat), 32'(waits));
        end
        @(posedge clk);                // the transfer completes on this edge
        #5;
        req.stb = 1'b0;
        req.cyc = 1'b0;
    endtask

    // pins and display follow the model on every cycle
    always @(negedge clk) begin : output_monitor
        int k;
        if (mon_en) begin
            check_value("gpio_o", 32'(model_out), 32'(gpio_out));
            check_value("gpio_oe_o", 32'(model_dir), 32'(gpio_oe));
            k = 0;
            for (int i = 0; i < 4; i++) begin
                if (!an[i]) k = i;
            end
            assert ($countones(an) == 3) else begin
                protocol_errors++;
                $display("an_o is %b, which does not enable exactly one digit", an);
            end
            check_value("seg_o", 32'(seg_pattern(model_value[4*k +: 4], model_dp[k])), 32'(seg));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d wrong values, %0d protocol errors",
                     value_errors, protocol_errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] g;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] rdata;
        logic [31:0] expected;
        logic        wen;
        logic        acked;
        logic [3:0]  sel;
        logic [3:0]  zero_seen;
        int          lat;
        string       name;
        lcg_state = 32'he301;
        rst = 1'b1;
        req = '0;
        gpio_in = '0;
        mon_en = 1'b0;
        model_out = '0;
        model_dir = '0;
        model_value = '0;
        model_dp = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_ram[i] = '0;
        end
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        mon_en = 1'b1;

        // idle after reset shows no ack, pins off and a 0 on each digit
        zero_seen = '0;
        for (int c = 0; c < 64; c++) begin
            @(negedge clk);
            if (c == 0) begin
                check_value("digit after reset", 32'hE, 32'(an)); // scan starts at digit 0
            end
            check_value("ack after reset", 32'd0, 32'(rsp.ack));
            check_value("gpio_o after reset", 32'd0, 32'(gpio_out));
            check_value("gpio_oe_o after reset", 32'd0, 32'(gpio_oe));
            for (int i = 0; i < 4; i++) begin
                if (!an[i] && seg == 8'hC0) zero_seen[i] = 1'b1;
            end
        end
        assert (zero_seen == 4'hF) else begin
            protocol_errors++;
            $display("display did not show 0 on all four digits after reset");
        end
        @(posedge clk);
        #5;

        for (int n = 0; n < NUM_TRANSFERS; n++) begin
            r   = next_rand();
            dat = next_rand();
            g   = next_rand();
            gpio_in = g[`GPIO_COUNT-1:0];
            wen = r[29];
            sel = r[27:24];
            expected = '0;
            lat = 0;
            case (r[31:30])
                2'd0: begin
                    // mostly a small window so reads hit earlier writes
                    adr = `RAM_ADDR | (r[23] ? {20'b0, r[11:0]} : {26'b0, r[5:0]});
                    expected = model_ram[adr[`RAMABITS-1:0]];
                    lat = 1;
                    name = "ram read";
                end
                2'd1: begin
                    adr = `GPIO_ADDR + {30'b0, r[1:0]};
                    if (r[1:0] == 2'd0) begin
                        for (int b = 0; b < `GPIO_COUNT; b++) begin
                            expected[b] = model_dir[b] ? model_out[b] : gpio_in[b];
                        end
                    end else if (r[1:0] == 2'd1) begin
                        expected = 32'(model_dir);
                    end
                    name = "gpio read";
                end
                2'd2: begin
                    adr = `SEG7_ADDR + {31'b0, r[0]};
                    expected = r[0] ? 32'(model_dp) : 32'(model_value);
                    name = "seg7 read";
                end
                default: begin
                    adr = r[22] ? (32'h8000_0000 | r) : (32'h0000_0104 + {30'b0, r[1:0]});
                    expected = 32'hFFFF_FFFF;
                    name = "unmapped read";
                end
            endcase
            bus_transfer(adr, dat, wen, sel, lat, rdata, acked);
            if (acked && !wen) begin
                check_value(name, expected, rdata);
            end
            if (acked && wen) begin
                case (r[31:30])
                    2'd0: begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) model_ram[adr[`RAMABITS-1:0]][8*b +: 8] = dat[8*b +: 8];
                        end
                    end
                    2'd1: begin
                        if (r[1:0] == 2'd0) model_out = dat[`GPIO_COUNT-1:0];
                        if (r[1:0] == 2'd1) model_dir = dat[`GPIO_COUNT-1:0];
                    end
                    2'd2: begin
                        if (r[0]) model_dp = dat[3:0];
                        else model_value = dat[15:0];
                    end
                    default: ;      // default slave drops writes
                endcase
            end
            if (r[17:15] == 3'd0) begin
                @(posedge clk);     // occasional idle cycle between transfers
                #5;
            end
        end

        $display("errors: %0d wrong values, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/block_ram.sv */
`default_nettype none

`include "tenyr_consts.svh"

module block_ram
    import tenyr_bus_pkg::*;
#(
    parameter int ABITS = `RAMABITS
) (
    input  wire           clk_i,
    input  wire           rst_i,
    input  wire bus_req_t req_i,
    output bus_rsp_t      rsp_o
);

    localparam int DEPTH = 1 << ABITS;

    logic [31:0]      mem [DEPTH];
    logic [31:0]      rd_q;     // read word, valid with ack_q
    logic             ack_q;
    logic             access;
    logic [ABITS-1:0] idx;

    assign access = req_i.stb & req_i.cyc;
    assign idx    = req_i.adr[ABITS-1:0]; // mux already checked the upper bits

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // ack the cycle after stb, then rest for one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access & ~ack_q;
        end
    end

    always_ff @(posedge clk_i) begin
        // writes land on the edge that completes the transfer
        if (access && ack_q && req_i.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
        if (access && !ack_q) begin
            rd_q <= mem[idx]; // first cycle of the access
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

/* hw/bus_mux.sv */
`default_nettype none

`include "tenyr_consts.svh"

module bus_mux
    import tenyr_bus_pkg::*;
    import tenyr_dev_pkg::*;
(
    input  wire bus_req_t req_i,       // from the master
    output bus_rsp_t      rsp_o,       // back to the master

    output bus_req_t      ram_req_o,
    output bus_req_t      seg7_req_o,
    output bus_req_t      gpio_req_o,

    input  wire bus_rsp_t ram_rsp_i,
    input  wire bus_rsp_t seg7_rsp_i,
    input  wire bus_rsp_t gpio_rsp_i
);

    dev_sel_t dev_sel;
    logic     hit_gpio;
    logic     hit_seg7;
    logic     hit_ram;
    logic     active;

    assign hit_gpio = (req_i.adr & `GPIO_MASK) == `GPIO_ADDR;
    assign hit_seg7 = (req_i.adr & `SEG7_MASK) == `SEG7_ADDR;
    assign hit_ram  = (req_i.adr & `RAM_MASK)  == `RAM_ADDR;

    assign active = req_i.stb & req_i.cyc;

    // small windows win over the larger ram window
    always_comb begin
        if (hit_gpio) begin
            dev_sel = DEV_GPIO;
        end else if (hit_seg7) begin
            dev_sel = DEV_SEG7;
        end else if (hit_ram) begin
            dev_sel = DEV_RAM;
        end else begin
            dev_sel = DEV_NONE;
        end
    end

    // every slave sees the same request and only the selected one is strobed
    always_comb begin
        ram_req_o      = req_i;
        ram_req_o.stb  = req_i.stb & (dev_sel == DEV_RAM);
        ram_req_o.cyc  = req_i.cyc & (dev_sel == DEV_RAM);

        seg7_req_o     = req_i;
        seg7_req_o.stb = req_i.stb & (dev_sel == DEV_SEG7);
        seg7_req_o.cyc = req_i.cyc & (dev_sel == DEV_SEG7);

        gpio_req_o     = req_i;
        gpio_req_o.stb = req_i.stb & (dev_sel == DEV_GPIO);
        gpio_req_o.cyc = req_i.cyc & (dev_sel == DEV_GPIO);
    end

    // steer the selected response back to the master
    always_comb begin
        case (dev_sel)
            DEV_RAM: begin
                rsp_o = ram_rsp_i;
            end
            DEV_SEG7: begin
                rsp_o = seg7_rsp_i;
            end
            DEV_GPIO: begin
                rsp_o = gpio_rsp_i;
            end
            default: begin
                // default slave answers at once and drops writes
                rsp_o.dat = '1;
                rsp_o.ack = active;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/gpio_port.sv */
`default_nettype none

`include "tenyr_consts.svh"

module gpio_port
    import tenyr_bus_pkg::*;
#(
    parameter int COUNT = `GPIO_COUNT // up to 32 pins
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire bus_req_t    req_i,
    output bus_rsp_t         rsp_o,
    input  wire  [COUNT-1:0] gpio_i,
    output logic [COUNT-1:0] gpio_o,
    output logic [COUNT-1:0] gpio_oe_o   // 1 = pin driven by gpio_o
);

    logic [COUNT-1:0] out_q;
    logic [COUNT-1:0] dir_q;
    logic [COUNT-1:0] pins;   // what the pins look like from the bus
    logic             access;

    assign access = req_i.stb & req_i.cyc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q <= '0;
            dir_q <= '0;     // everything an input
        end else if (access && req_i.wen) begin
            case (req_i.adr[1:0])
                2'd0: out_q <= req_i.dat[COUNT-1:0];
                2'd1: dir_q <= req_i.dat[COUNT-1:0];
                default: ;   // offsets 2 and 3 are reserved
            endcase
        end
    end

    // driven pins read back the output register, the rest read the input
    assign pins = (out_q & dir_q) | (gpio_i & ~dir_q);

    always_comb begin
        case (req_i.adr[1:0])
            2'd0:    rsp_o.dat = 32'(pins);
            2'd1:    rsp_o.dat = 32'(dir_q);
            default: rsp_o.dat = '0;
        endcase
        rsp_o.ack = access;
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

/* hw/seg7_ctrl.sv */
`default_nettype none

`include "tenyr_consts.svh"

module seg7_ctrl
    import tenyr_bus_pkg::*;
    import tenyr_dev_pkg::*;
(
    input  wire           clk_i,
    input  wire           rst_i,
    input  wire bus_req_t req_i,
    output bus_rsp_t      rsp_o,
    output logic [7:0]    seg_o,  // active low with the point in bit 7
    output logic [3:0]    an_o    // active low digit enables
);

    localparam int CNT_BITS = `SEG7_SCAN_BITS + 2;

    logic [15:0]         value_q;  // four hex digits, digit 0 in the low nibble
    logic [3:0]          dp_q;     // decimal point per digit
    logic [CNT_BITS-1:0] scan_q;
    logic [1:0]          digit;
    seg7_digit_t         nibble;
    logic                access;

    // lit segments a..g are ones in bits 0..6
    function automatic logic [6:0] hex_segments(input seg7_digit_t d);
        case (d)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    assign access = req_i.stb & req_i.cyc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            value_q <= '0;
            dp_q    <= '0;
            scan_q  <= '0;
        end else begin
            scan_q <= scan_q + 1'b1; // free running
            if (access && req_i.wen) begin
                if (req_i.adr[0]) begin
                    dp_q <= req_i.dat[3:0];
                end else begin
                    value_q <= req_i.dat[15:0];
                end
            end
        end
    end

    // register reads are zero extended and answered in the same cycle
    assign rsp_o.dat = req_i.adr[0] ? {28'b0, dp_q} : {16'b0, value_q};
    assign rsp_o.ack = access;

    assign digit  = scan_q[CNT_BITS-1 -: 2];
    assign nibble = value_q[4*digit +: 4];

    assign an_o  = ~(4'b0001 << digit);
    assign seg_o = {~dp_q[digit], ~hex_segments(nibble)};

endmodule

`default_nettype wire

/* hw/tenyr_bus_pkg.sv */
`default_nettype none

package tenyr_bus_pkg;

    // request as driven by the bus master
    // adr, dat, wen and sel are held steady from stb until ack
    typedef struct packed {
        logic [31:0] adr; // word address
        logic [31:0] dat; // write data
        logic        wen; // 1 = write
        logic [3:0]  sel; // byte lanes, bit 0 is dat[7:0]
        logic        stb; // strobe
        logic        cyc; // cycle in progress
    } bus_req_t;

    // response returned by a slave
    // dat only carries meaning while ack is high on a read
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* hw/tenyr_dev_pkg.sv */
`default_nettype none

package tenyr_dev_pkg;

    // which slave the current master address falls in
    typedef enum logic [1:0] {
        DEV_RAM  = 2'd0,
        DEV_SEG7 = 2'd1,
        DEV_GPIO = 2'd2,
        DEV_NONE = 2'd3   // default slave, reads all ones
    } dev_sel_t;

    // one hex digit on the seven-segment display
    typedef logic [3:0] seg7_digit_t;

endpackage

`default_nettype wire

/* hw/tenyr_soc.sv */
`default_nettype none

`include "tenyr_consts.svh"

module tenyr_soc
    import tenyr_bus_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    rst_i,
    input  wire bus_req_t          req_i,     // core data port
    output bus_rsp_t               rsp_o,
    input  wire  [`GPIO_COUNT-1:0] gpio_i,
    output logic [`GPIO_COUNT-1:0] gpio_o,
    output logic [`GPIO_COUNT-1:0] gpio_oe_o,
    output logic [7:0]             seg_o,
    output logic [3:0]             an_o
);

    bus_req_t ram_req;
    bus_req_t seg7_req;
    bus_req_t gpio_req;
    bus_rsp_t ram_rsp;
    bus_rsp_t seg7_rsp;
    bus_rsp_t gpio_rsp;

    bus_mux mux0 (
        .req_i      (req_i),
        .rsp_o      (rsp_o),
        .ram_req_o  (ram_req),
        .seg7_req_o (seg7_req),
        .gpio_req_o (gpio_req),
        .ram_rsp_i  (ram_rsp),
        .seg7_rsp_i (seg7_rsp),
        .gpio_rsp_i (gpio_rsp)
    );

    // program and data memory at the reset vector
    block_ram #(.ABITS(`RAMABITS)) ram0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    seg7_ctrl seg7_0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (seg7_req),
        .rsp_o (seg7_rsp),
        .seg_o (seg_o),
        .an_o  (an_o)
    );

    gpio_port #(.COUNT(`GPIO_COUNT)) gpio0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (gpio_req),
        .rsp_o     (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule

`default_nettype wire

/* include/tenyr_consts.svh */
`ifndef TENYR_CONSTS_SVH
`define TENYR_CONSTS_SVH

// word address map of the device side
`define RESETVECTOR 32'h0000_1000 // first instruction fetched after reset
`define RAMABITS    12            // 4096 words, 0x1000 to 0x1fff

`define RAM_ADDR    `RESETVECTOR
`define RAM_MASK    32'hFFFF_F000

// gpio block decodes four words
`define GPIO_ADDR   32'h0000_0200
`define GPIO_MASK   32'hFFFF_FFFC

// display block decodes two words
`define SEG7_ADDR   32'h0000_0100
`define SEG7_MASK   32'hFFFF_FFFE

// low bits of the scan counter divide the clock; the top two pick the digit
`define SEG7_SCAN_BITS 4

`define GPIO_COUNT  24

`endif

/* sources.f */
+incdir+include
hw/tenyr_bus_pkg.sv
hw/tenyr_dev_pkg.sv
hw/bus_mux.sv
hw/block_ram.sv
hw/seg7_ctrl.sv
hw/gpio_port.sv
hw/tenyr_soc.sv
bench/tenyr_soc_tb.sv
